//--- common/memory_map_pkg.sv
package memory_map_pkg;

    // Transmitter window, every offset maps to the one data/status register
    localparam logic [31:0] uart_tx_offset = 32'hF000_0000;
    localparam logic [31:0] uart_tx_end    = 32'hF000_000F;

    // Receiver window
    localparam logic [31:0] uart_rx_offset = 32'hF000_0010;
    localparam logic [31:0] uart_rx_end    = 32'hF000_001F;

    // Main memory is 1024 words of 32 bits (4096 bytes)
    localparam int memory_words     = 1024;
    localparam int memory_addr_bits = 10;   // Word index width, addr bits 11 to 2

    // UART bit period in clock cycles, kept short so frames simulate quickly
    localparam int clks_per_bit = 8;
    localparam int clk_cnt_bits = $clog2(clks_per_bit);

    // Decoded target of a bus address
    localparam logic [1:0] region_mem = 2'd0;
    localparam logic [1:0] region_tx  = 2'd1;
    localparam logic [1:0] region_rx  = 2'd2;

endpackage

//--- list.f
common/memory_map_pkg.sv
rtl/main_memory.sv
uart/uart_tx.sv
uart/uart_rx.sv
rtl/memory_map_controller.sv
rtl/soc_bus_top.sv
verification/soc_bus_assert.sv
verification/tb_soc_bus.sv

//--- rtl/main_memory.sv
module main_memory (
    input  logic        clk,
    input  logic        rst,

    input  logic        cmd_start,
    input  logic        cmd_write,
    output logic        cmd_ready,

    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rdata_valid
);

    import memory_map_pkg::*;

    logic [31:0]                 mem [memory_words];
    logic [memory_addr_bits-1:0] word_idx;

    // Byte address to word index, higher bits alias
    assign word_idx = addr[memory_addr_bits+1:2];

    // Storage and read register
    always_ff @(posedge clk) begin
        if (cmd_start) begin
            if (cmd_write) begin
                mem[word_idx] <= wdata;
            end else begin
                rdata <= mem[word_idx];
            end
        end
    end

    // Handshake state, busy for one cycle after every accepted command
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ready   <= 1'b1;
            rdata_valid <= 1'b0;
        end else begin
            cmd_ready   <= !cmd_start;
            rdata_valid <= cmd_start && !cmd_write;  // Read data shows up the next cycle
        end
    end

endmodule

//--- rtl/memory_map_controller.sv
module memory_map_controller (
    input  logic        clk,
    input  logic        rst,

    input  logic        cmd_start,
    input  logic        cmd_write,
    output logic        cmd_ready,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rdata_valid,

    output logic        mem_start,
    output logic        mem_write,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input  logic        mem_ready,
    input  logic        mem_rdata_valid,
    input  logic [31:0] mem_rdata,

    output logic        tx_start,
    output logic        tx_write,
    output logic [31:0] tx_wdata,
    input  logic        tx_ready,
    input  logic        tx_rdata_valid,
    input  logic [31:0] tx_rdata,

    output logic        rx_start,
    output logic        rx_write,
    input  logic        rx_ready,
    input  logic        rx_rdata_valid,
    input  logic [31:0] rx_rdata
);

    import memory_map_pkg::*;

    logic [1:0] sel_region;    // Region of the current addr
    logic [1:0] held_region;   // Region of the access in flight
    logic       access_active;
    logic [1:0] resp_region;

    always_comb begin
        if (addr >= uart_tx_offset && addr <= uart_tx_end) begin
            sel_region = region_tx;
        end else if (addr >= uart_rx_offset && addr <= uart_rx_end) begin
            sel_region = region_rx;
        end else begin
            sel_region = region_mem;  // Everything else is main memory
        end
    end

    // Only the decoded target sees the command
    assign mem_start = cmd_start && sel_region == region_mem;
    assign mem_write = cmd_write && sel_region == region_mem;
    assign tx_start  = cmd_start && sel_region == region_tx;
    assign tx_write  = cmd_write && sel_region == region_tx;
    assign rx_start  = cmd_start && sel_region == region_rx;
    assign rx_write  = cmd_write && sel_region == region_rx;

    assign mem_addr  = addr;  // Default region is not rebased
    assign mem_wdata = wdata;
    assign tx_wdata  = wdata;

    assign resp_region = access_active ? held_region : sel_region;

    always_comb begin
        case (resp_region)
            region_tx: begin
                cmd_ready   = tx_ready;
                rdata       = tx_rdata;
                rdata_valid = tx_rdata_valid;
            end
            region_rx: begin
                cmd_ready   = rx_ready;
                rdata       = rx_rdata;
                rdata_valid = rx_rdata_valid;
            end
            default: begin
                cmd_ready   = mem_ready;
                rdata       = mem_rdata;
                rdata_valid = mem_rdata_valid;
            end
        endcase
    end

    // Hold the region until the target is ready again or has answered the read
    always_ff @(posedge clk) begin
        if (rst) begin
            access_active <= 1'b0;
            held_region   <= region_mem;
        end else if (cmd_start) begin
            access_active <= 1'b1;
            held_region   <= sel_region;
        end else if (access_active && (cmd_ready || rdata_valid)) begin
            access_active <= 1'b0;
        end
    end

endmodule

//--- rtl/soc_bus_top.sv
module soc_bus_top (
    input  logic        clk,
    input  logic        rst,

    input  logic        cmd_start,
    input  logic        cmd_write,
    output logic        cmd_ready,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rdata_valid,

    input  logic        uart_rx,
    output logic        uart_tx
);

    logic        mem_start;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ready;
    logic        mem_rdata_valid;
    logic [31:0] mem_rdata;

    logic        tx_start;
    logic        tx_write;
    logic [31:0] tx_wdata;
    logic        tx_ready;
    logic        tx_rdata_valid;
    logic [31:0] tx_rdata;

    logic        rx_start;
    logic        rx_write;
    logic        rx_ready;
    logic        rx_rdata_valid;
    logic [31:0] rx_rdata;

    memory_map_controller u_controller (
        .clk             (clk),
        .rst             (rst),
        .cmd_start       (cmd_start),
        .cmd_write       (cmd_write),
        .cmd_ready       (cmd_ready),
        .addr            (addr),
        .wdata           (wdata),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_start       (mem_start),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_ready       (mem_ready),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata),
        .tx_start        (tx_start),
        .tx_write        (tx_write),
        .tx_wdata        (tx_wdata),
        .tx_ready        (tx_ready),
        .tx_rdata_valid  (tx_rdata_valid),
        .tx_rdata        (tx_rdata),
        .rx_start        (rx_start),
        .rx_write        (rx_write),
        .rx_ready        (rx_ready),
        .rx_rdata_valid  (rx_rdata_valid),
        .rx_rdata        (rx_rdata)
    );

    main_memory u_memory (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (mem_start),
        .cmd_write   (mem_write),
        .cmd_ready   (mem_ready),
        .addr        (mem_addr),
        .wdata       (mem_wdata),
        .rdata       (mem_rdata),
        .rdata_valid (mem_rdata_valid)
    );

    uart_tx u_uart_tx (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (tx_start),
        .cmd_write   (tx_write),
        .cmd_ready   (tx_ready),
        .wdata       (tx_wdata),
        .rdata       (tx_rdata),
        .rdata_valid (tx_rdata_valid),
        .uart_tx     (uart_tx)
    );

    uart_rx u_uart_rx (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (rx_start),
        .cmd_write   (rx_write),
        .cmd_ready   (rx_ready),
        .rdata       (rx_rdata),
        .rdata_valid (rx_rdata_valid),
        .uart_rx     (uart_rx)
    );

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the SoC bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_soc_bus
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f list.f -o "sim_$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

//--- uart/uart_rx.sv
module uart_rx (
    input  logic        clk,
    input  logic        rst,

    input  logic        cmd_start,
    input  logic        cmd_write,
    output logic        cmd_ready,

    output logic [31:0] rdata,
    output logic        rdata_valid,

    input  logic        uart_rx
);

    import memory_map_pkg::*;

    logic                    rx_meta;
    logic                    rx_sync;
    logic                    rx_active;   // Frame being received
    logic [clk_cnt_bits-1:0] clk_cnt;
    logic [3:0]              bit_idx;     // 0 is the start bit, 9 the stop bit
    logic                    sample;
    logic [7:0]              rx_shift;
    logic [7:0]              rx_byte;
    logic                    rx_valid;
    logic                    rd_accept;

    assign sample    = rx_active && clk_cnt == clk_cnt_bits'(clks_per_bit / 2 - 1);
    assign rd_accept = cmd_start && !cmd_write;

    // Writes are dropped, so only a read makes the block busy
    assign cmd_ready = !rdata_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta     <= 1'b1;
            rx_sync     <= 1'b1;
            rx_active   <= 1'b0;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            rx_meta     <= uart_rx;
            rx_sync     <= rx_meta;
            rdata_valid <= rd_accept;

            if (rd_accept) begin
                rx_valid <= 1'b0;
            end

            if (!rx_active) begin
                if (!rx_sync) begin
                    // Falling edge, sampling starts half a bit from here
                    rx_active <= 1'b1;
                    clk_cnt   <= '0;
                    bit_idx   <= '0;
                end
            end else begin
                clk_cnt <= (clk_cnt == clk_cnt_bits'(clks_per_bit - 1)) ? '0 : clk_cnt + 1'b1;
                if (sample) begin
                    bit_idx <= bit_idx + 4'd1;
                    if (bit_idx == 4'd0 && rx_sync) begin
                        rx_active <= 1'b0;  // Glitch, not a real start bit
                    end else if (bit_idx == 4'd9) begin
                        rx_active <= 1'b0;
                        if (rx_sync) begin
                            rx_valid <= 1'b1;  // Wins over a read clear in the same cycle
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        if (sample && bit_idx == 4'd9 && rx_sync) begin
            rx_byte <= rx_shift;  // A newer byte replaces an unread one
        end
        if (rd_accept) begin
            rdata <= {23'd0, rx_valid, rx_byte};
        end
    end

endmodule

//--- uart/uart_tx.sv
module uart_tx (
    input  logic        clk,
    input  logic        rst,

    input  logic        cmd_start,
    input  logic        cmd_write,
    output logic        cmd_ready,

    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rdata_valid,

    output logic        uart_tx
);

    import memory_map_pkg::*;

    logic                    busy;       // Frame on the line
    logic [9:0]              tx_shift;   // Stop bit, data, start bit; bit 0 is on the line
    logic [clk_cnt_bits-1:0] clk_cnt;
    logic [3:0]              bit_idx;
    logic                    bit_done;

    assign bit_done = clk_cnt == clk_cnt_bits'(clks_per_bit - 1);

    // Line idles high between frames
    assign uart_tx = busy ? tx_shift[0] : 1'b1;

    // Not ready while a frame is sent or a status read is returned
    assign cmd_ready = !busy && !rdata_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cmd_start && !cmd_write;
            if (cmd_start && cmd_write) begin
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end else if (busy) begin
                if (bit_done) begin
                    clk_cnt <= '0;
                    if (bit_idx == 4'd9) begin
                        busy <= 1'b0;  // Stop bit has ended
                    end else begin
                        bit_idx <= bit_idx + 4'd1;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end
        end
    end

    // Frame data and status word
    always_ff @(posedge clk) begin
        if (cmd_start && cmd_write) begin
            tx_shift <= {1'b1, wdata[7:0], 1'b0};
        end else if (busy && bit_done) begin
            tx_shift <= {1'b1, tx_shift[9:1]};  // LSB first
        end
        if (cmd_start && !cmd_write) begin
            rdata <= {31'd0, busy};
        end
    end

endmodule

//--- verification/soc_bus_assert.sv
module soc_bus_assert (
    input logic clk,
    input logic rst,
    input logic cmd_start,
    input logic cmd_write,
    input logic cmd_ready,
    input logic rdata_valid,
    input logic mem_start,
    input logic tx_start,
    input logic rx_start
);

    logic read_pending;  // A read was accepted and has not answered yet

    always_ff @(posedge clk) begin
        if (rst) begin
            read_pending <= 1'b0;
        end else if (cmd_start && !cmd_write) begin
            read_pending <= 1'b1;
        end else if (rdata_valid) begin
            read_pending <= 1'b0;
        end
    end

    start_needs_ready: assert property (@(posedge clk) disable iff (rst)
        cmd_start |-> cmd_ready)
        else $error("cmd_start while cmd_ready is low");

    one_target_start: assert property (@(posedge clk) disable iff (rst)
        $onehot0({mem_start, tx_start, rx_start}))
        else $error("More than one target start is high");

    valid_after_read: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> read_pending)
        else $error("rdata_valid without an accepted read");

    ready_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> cmd_ready)
        else $error("cmd_ready low in the cycle after reset");

endmodule

bind memory_map_controller soc_bus_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .cmd_start   (cmd_start),
    .cmd_write   (cmd_write),
    .cmd_ready   (cmd_ready),
    .rdata_valid (rdata_valid),
    .mem_start   (mem_start),
    .tx_start    (tx_start),
    .rx_start    (rx_start)
);

//--- verification/tb_soc_bus.sv
module tb_soc_bus;

    import memory_map_pkg::*;

    localparam int ready_timeout = 200;  // Cycles, longer than one UART frame
    localparam int valid_timeout = 8;
    localparam int poll_limit    = 16;
    localparam logic [31:0] rx_addr = uart_rx_offset + 32'd8;

    logic        clk;
    logic        rst;
    logic        cmd_start;
    logic        cmd_write;
    logic        cmd_ready;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        serial_line;  // Transmitter looped back into the receiver

    integer seed = 32'h17f3d76c;

    logic [31:0] mem_model [int];  // Indexed by word index
    logic [7:0]  model_rx_byte;
    logic        model_rx_flag;
    logic [31:0] expected_q [$];
    logic [7:0]  decoded_q [$];
    int          written_idx [$];

    soc_bus_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .uart_rx     (serial_line),
        .uart_tx     (serial_line)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic bit in_tx(input logic [31:0] a);
        return a >= uart_tx_offset && a <= uart_tx_end;
    endfunction

    function automatic bit in_rx(input logic [31:0] a);
        return a >= uart_rx_offset && a <= uart_rx_end;
    endfunction

    // Expected read word for the model state at the moment the read is issued
    function automatic logic [31:0] expected_read(input logic [31:0] a);
        if (in_tx(a)) begin
            return 32'd0;  // A read only starts once the frame has ended
        end else if (in_rx(a)) begin
            return {23'd0, model_rx_flag, model_rx_byte};
        end else if (mem_model.exists(int'(a[memory_addr_bits+1:2]))) begin
            return mem_model[int'(a[memory_addr_bits+1:2])];
        end
        return 'x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s: actual 0x%08h expected 0x%08h",
                                name, actual, expected));
        end
    endtask

    // Moves to the drive point, a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // Returns just before the edge at which cmd_ready was seen high
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        #30;
        while (!cmd_ready) begin
            cycles++;
            if (cycles > ready_timeout) begin
                abort_run("Timeout while waiting for cmd_ready");
            end
            next_cycle();
            #30;
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        addr      = a;
        wdata     = d;
        cmd_write = 1'b1;
        wait_ready();
        next_cycle();
        cmd_start = 1'b1;
        if (in_tx(a)) begin
            // Mid-bit sampling takes the stop bit before the transmitter frees the bus
            model_rx_byte = d[7:0];
            model_rx_flag = 1'b1;
        end else if (!in_rx(a)) begin
            mem_model[int'(a[memory_addr_bits+1:2])] = d;
        end
        next_cycle();
        cmd_start = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        int lat;
        addr      = a;
        cmd_write = 1'b0;
        wait_ready();
        next_cycle();
        expected_q.push_back(expected_read(a));
        cmd_start = 1'b1;
        next_cycle();
        cmd_start = 1'b0;
        lat = 1;
        #30;
        while (!rdata_valid) begin
            lat++;
            if (lat > valid_timeout) begin
                abort_run("Timeout while waiting for rdata_valid");
            end
            next_cycle();
            #30;
        end
        d = rdata;
        check_value("read latency", 32'(lat), 32'd1);
        if (in_rx(a)) begin
            model_rx_flag = 1'b0;  // The read clears the receiver flag
        end
        next_cycle();
    endtask

    task automatic check_loopback(input logic [7:0] sent);
        logic [31:0] got;
        int          polls;
        polls = 0;
        got   = 32'd0;
        while (!got[8]) begin
            polls++;
            if (polls > poll_limit) begin
                abort_run("Receiver never reported a valid byte");
            end
            bus_read(rx_addr, got);
        end
        check_value("rx byte", 32'(got[7:0]), 32'(sent));
        bus_read(rx_addr, got);
        check_value("rx valid after read", 32'(got[8]), 32'd0);
        if (decoded_q.size() != 1) begin
            abort_run("Line decoder did not see exactly one frame on uart_tx");
        end else begin
            check_value("uart_tx line byte", 32'(decoded_q.pop_front()), 32'(sent));
        end
    endtask

    // Every read response is compared with the word expected when it was issued
    initial begin : compare_proc
        logic [31:0] exp_word;
        forever begin
            @(posedge clk);
            #35;
            if (!rst && rdata_valid) begin
                if (expected_q.size() == 0) begin
                    abort_run("rdata_valid arrived with no read outstanding");
                end else begin
                    exp_word = expected_q.pop_front();
                    check_value("rdata", rdata, exp_word);
                end
            end
        end
    end

    // Decodes 8N1 frames on the line at mid-bit
    initial begin : line_decoder
        bit         active;
        int         tick;
        int         bit_pos;
        logic [7:0] shift;
        active = 1'b0;
        tick   = 0;
        shift  = 8'd0;
        forever begin
            @(posedge clk);
            #35;
            if (rst) begin
                active = 1'b0;
            end else if (!active) begin
                if (!serial_line) begin
                    active = 1'b1;  // First sample inside the start bit
                    tick   = 1;
                end
            end else begin
                tick++;
                if ((tick - clks_per_bit / 2 - 1) % clks_per_bit == 0) begin
                    bit_pos = (tick - clks_per_bit / 2 - 1) / clks_per_bit;
                    if (bit_pos == 0 && serial_line) begin
                        abort_run("Start bit on uart_tx did not last to mid-bit");
                    end else if (bit_pos >= 1 && bit_pos <= 8) begin
                        shift[bit_pos-1] = serial_line;
                    end else if (bit_pos == 9) begin
                        if (!serial_line) begin
                            abort_run("Stop bit on uart_tx is low");
                        end
                        decoded_q.push_back(shift);
                        active = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] got;
        logic [31:0] tx_addr;
        logic [7:0]  sent;
        int          idx;
        int          busy_cycles;
        rst           = 1'b1;
        cmd_start     = 1'b0;
        cmd_write     = 1'b0;
        addr          = 32'd0;
        wdata         = 32'd0;
        model_rx_flag = 1'b0;
        model_rx_byte = 8'd0;
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;

        #30;
        check_value("cmd_ready", 32'(cmd_ready), 32'd1);
        check_value("rdata_valid", 32'(rdata_valid), 32'd0);
        check_value("uart_tx", 32'(serial_line), 32'd1);
        next_cycle();

        // Main memory, addresses up to 16 KB so the upper bits alias
        for (int i = 0; i < 200; i++) begin
            a = 32'($random(seed)) & 32'h0000_3FFC;
            d = 32'($random(seed));
            bus_write(a, d);
            #30;
            check_value("rdata_valid after write", 32'(rdata_valid), 32'd0);
            next_cycle();
            written_idx.push_back(int'(a[memory_addr_bits+1:2]));
            idx = written_idx[{$random(seed)} % written_idx.size()];
            a   = (32'(idx) << 2) | ((32'($random(seed)) & 32'h3) << 12);
            bus_read(a, got);
        end

        // Transmitter holds the bus for a whole frame
        tx_addr = uart_tx_offset + 32'd4;
        sent    = 8'hA5;
        bus_write(tx_addr, {24'd0, sent});
        busy_cycles = 0;
        #30;
        while (!cmd_ready) begin
            busy_cycles++;
            if (busy_cycles > ready_timeout) begin
                abort_run("Transmitter never returned cmd_ready");
            end
            next_cycle();
            #30;
        end
        check_value("tx busy cycles", 32'(busy_cycles), 32'(10 * clks_per_bit));
        next_cycle();
        bus_read(tx_addr, got);
        check_value("tx busy flag", got, 32'd0);
        check_loopback(sent);

        for (int i = 0; i < 8; i++) begin
            tx_addr = uart_tx_offset + 32'({$random(seed)} % 16);
            sent    = 8'($random(seed));
            bus_write(tx_addr, {24'd0, sent});
            check_loopback(sent);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
